/* versat_io.f */
source/versat_io_pkg.sv
source/cpu_reg_decode.sv
source/io_copy_unit.sv
source/bus_merge.sv
source/scratch_mem.sv
source/versat_io_top.sv
verif/versat_io_tb.sv

/* Makefile */
# Verilator flow for the versat_io testbench
TOP = versat_io_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f versat_io.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/versat_io_tb.sv */
`timescale 1ns/1ps

module versat_io_tb;
   import versat_io_pkg::*;

   localparam int MAX_CYCLES  = 20000;
   localparam int READY_LIMIT = 50;
   // default memory wait of the DUT
   localparam int MEM_WAIT    = 2;

   logic      clk   = 1'b0;
   logic      rst   = 1'b1;
   logic      valid = 1'b0;
   cpu_addr_t addr  = '0;
   data_t     wdata = '0;
   strb_t     wstrb = '0;
   data_t     rdata;
   logic      ready;

   // expected contents of the scratch memory
   data_t       model [MEM_WORDS];
   logic [31:0] lfsr       = 32'hec37;
   int          cycles     = 0;
   int          mismatches = 0;
   int          failures   = 0;

   versat_io_top versat_io_top_i (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .wstrb (wstrb),
      .rdata (rdata),
      .ready (ready)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic data_t rand_bits(input int n);
      data_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[DATA_W-2:0], lfsr[0]};
      end
      return r;
   endfunction

   // neither empty nor full
   function automatic strb_t partial_strb();
      strb_t s;
      s = strb_t'(rand_bits(STRB_W));
      if (s == '0 || s == '1) begin
         s = 4'b0110;
      end
      return s;
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t d, input strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < STRB_W; b++) begin
         if (s[b]) begin
            r[8*b +: 8] = d[8*b +: 8];
         end
      end
      return r;
   endfunction

   function automatic cpu_addr_t reg_addr(input int unit, input reg_sel_e sel);
      return cpu_addr_t'((unit << UNIT_LSB) | int'(sel));
   endfunction

   function automatic cpu_addr_t win_addr(input int a);
      return cpu_addr_t'((1 << WIN_BIT) | (a % MEM_WORDS));
   endfunction

   // fields held until ready and valid dropped at the next edge
   task automatic cpu_access(input cpu_addr_t a, input data_t d, input strb_t s,
                             output data_t q);
      int n;
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ready && n < READY_LIMIT);
      // n counts the valid cycles up to and including the ready cycle
      if (!ready) begin
         $display("no ready within %0d cycles for the access to address %h", READY_LIMIT, a);
         failures++;
      end else if (!a[WIN_BIT] && n != 2) begin
         $display("register access to address %h ended after %0d cycles, not 1", a, n - 1);
         failures++;
      end else if (a[WIN_BIT] && n - 1 < MEM_WAIT) begin
         $display("memory access to address %h ended after %0d cycles, too early", a, n - 1);
         failures++;
      end
      q = rdata;
      @(posedge clk);
      valid <= 1'b0;
      @(negedge clk);
      if (ready) begin
         $display("ready stayed high after the access to address %h ended", a);
         failures++;
      end
   endtask

   task automatic cpu_write(input cpu_addr_t a, input data_t d, input strb_t s);
      data_t q;
      cpu_access(a, d, s, q);
   endtask

   task automatic cpu_read(input cpu_addr_t a, output data_t q);
      cpu_access(a, '0, '0, q);
   endtask

   task automatic write_word(input int a, input data_t d, input strb_t s);
      cpu_write(win_addr(a), d, s);
      model[mem_addr_t'(a)] = merge_bytes(model[mem_addr_t'(a)], d, s);
   endtask

   task automatic check_word(input int a);
      data_t q;
      cpu_read(win_addr(a), q);
      if (q !== model[mem_addr_t'(a)]) begin
         $display("Mismatch at %0t: rdata of mem[%0d] expected %h, got %h",
                  $time, a, model[mem_addr_t'(a)], q);
         mismatches++;
      end
   endtask

   task automatic check_region(input int lo, input int hi);
      for (int a = lo; a < hi; a++) begin
         check_word(a);
      end
   endtask

   task automatic check_reg(input int unit, input reg_sel_e sel, input data_t exp);
      data_t q;
      cpu_read(reg_addr(unit, sel), q);
      if (q !== exp) begin
         $display("Mismatch at %0t: rdata of unit %0d %s expected %h, got %h",
                  $time, unit, sel.name(), exp, q);
         mismatches++;
      end
   endtask

   task automatic config_unit(input int unit, input int src, input int dst, input int len);
      cpu_write(reg_addr(unit, reg_src), data_t'(src), '1);
      cpu_write(reg_addr(unit, reg_dst), data_t'(dst), '1);
      cpu_write(reg_addr(unit, reg_len), data_t'(len), '1);
   endtask

   task automatic start_unit(input int unit);
      cpu_write(reg_addr(unit, reg_ctrl), 32'h1, '1);
   endtask

   task automatic wait_idle(input int unit);
      data_t q;
      do begin
         cpu_read(reg_addr(unit, reg_ctrl), q);
      end while (q[0] !== 1'b0);
   endtask

   task automatic copy_model(input int src, input int dst, input int len);
      for (int i = 0; i < len; i++) begin
         model[mem_addr_t'(dst + i)] = model[mem_addr_t'(src + i)];
      end
   endtask

   task automatic test_regs();
      data_t vals [$];
      int    n;
      for (int u = 0; u < 2; u++) begin
         for (int r = 0; r < 3; r++) begin
            vals.push_back(rand_bits(DATA_W));
            cpu_write(reg_addr(u, reg_sel_e'(r)), vals[vals.size()-1], '1);
         end
      end
      n = 0;
      for (int u = 0; u < 2; u++) begin
         for (int r = 0; r < 3; r++) begin
            check_reg(u, reg_sel_e'(r), vals[n] & 32'h0000_03ff);
            n++;
         end
         check_reg(u, reg_ctrl, '0);
      end
      // unit 9 does not exist
      for (int r = 0; r < 4; r++) begin
         check_reg(9, reg_sel_e'(r), '0);
      end
   endtask

   task automatic test_window();
      for (int a = 0; a < 16; a++) begin
         write_word(a, rand_bits(DATA_W), '1);
      end
      for (int a = 0; a < 16; a += 3) begin
         write_word(a, rand_bits(DATA_W), partial_strb());
      end
      check_region(0, 16);
   endtask

   task automatic test_cpu_during_copy();
      config_unit(0, 80, 84, 4);
      config_unit(1, 88, 92, 3);
      start_unit(0);
      start_unit(1);
      check_reg(0, reg_ctrl, 32'h1);
      check_reg(1, reg_ctrl, 32'h1);
      // window traffic competes with both units for the merge
      for (int a = 120; a < 124; a++) begin
         write_word(a, rand_bits(DATA_W), '1);
      end
      check_region(120, 124);
      wait_idle(0);
      wait_idle(1);
      copy_model(80, 84, 4);
      copy_model(88, 92, 3);
   endtask

   task automatic test_ignored_starts();
      config_unit(1, 96, 100, 0);
      start_unit(1);
      check_reg(1, reg_ctrl, '0);
      config_unit(0, 104, 112, 6);
      start_unit(0);
      config_unit(0, 100, 96, 3);
      start_unit(0);
      check_reg(0, reg_ctrl, 32'h1);
      wait_idle(0);
      copy_model(104, 112, 6);
      check_reg(0, reg_src, 32'd100);
      check_reg(0, reg_dst, 32'd96);
      check_reg(0, reg_len, 32'd3);
   endtask

   initial begin
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      test_regs();
      for (int a = 16; a < 128; a++) begin
         write_word(a, rand_bits(DATA_W), '1);
      end
      test_window();
      // single copy on unit 0
      config_unit(0, 16, 24, 8);
      start_unit(0);
      wait_idle(0);
      copy_model(16, 24, 8);
      check_region(0, 128);
      // both units on disjoint blocks
      config_unit(0, 32, 48, 12);
      config_unit(1, 64, 72, 5);
      start_unit(0);
      start_unit(1);
      wait_idle(0);
      wait_idle(1);
      copy_model(32, 48, 12);
      copy_model(64, 72, 5);
      check_region(0, 128);
      test_cpu_during_copy();
      check_region(0, 128);
      test_ignored_starts();
      check_region(0, 128);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* source/versat_io_top.sv */
`timescale 1ns/1ps

module versat_io_top
   import versat_io_pkg::*;
#(
   parameter int N_UNITS  = 2,
   parameter int MEM_WAIT = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      valid,
   input  cpu_addr_t addr,
   input  data_t     wdata,
   input  strb_t     wstrb,
   output data_t     rdata,
   output logic      ready
);

   copy_cfg_t [N_UNITS-1:0] cfg;
   logic [N_UNITS-1:0]      start;
   logic [N_UNITS-1:0]      busy;

   // master 0 is the cpu window, unit k is master k+1
   bus_req_t  [N_UNITS:0]   m_req;
   bus_resp_t [N_UNITS:0]   m_resp;
   bus_req_t                s_req;
   bus_resp_t               s_resp;

   cpu_reg_decode #(
      .N_UNITS (N_UNITS)
   ) decode (
      .clk      (clk),
      .rst      (rst),
      .valid    (valid),
      .addr     (addr),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .busy     (busy),
      .mem_resp (m_resp[0]),
      .rdata    (rdata),
      .ready    (ready),
      .cfg      (cfg),
      .start    (start),
      .mem_req  (m_req[0])
   );

   for (genvar k = 0; k < N_UNITS; k++) begin : g_exec
      io_copy_unit copy (
         .clk      (clk),
         .rst      (rst),
         .cfg      (cfg[k]),
         .start    (start[k]),
         .bus_resp (m_resp[k+1]),
         .busy     (busy[k]),
         .bus_req  (m_req[k+1])
      );
   end

   bus_merge #(
      .N_MASTERS (N_UNITS + 1)
   ) merge (
      .clk    (clk),
      .rst    (rst),
      .m_req  (m_req),
      .s_resp (s_resp),
      .m_resp (m_resp),
      .s_req  (s_req)
   );

   scratch_mem #(
      .MEM_WAIT (MEM_WAIT)
   ) mem (
      .clk  (clk),
      .rst  (rst),
      .req  (s_req),
      .resp (s_resp)
   );

endmodule

/* source/scratch_mem.sv */
`timescale 1ns/1ps

module scratch_mem
   import versat_io_pkg::*;
#(
   parameter int MEM_WAIT = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  bus_req_t  req,
   output bus_resp_t resp
);

   localparam int CNT_W = $clog2(MEM_WAIT + 1);

   data_t            mem [MEM_WORDS];
   logic [CNT_W-1:0] cnt;
   logic             ready_q;
   data_t            rdata_q;
   logic             fire;

   // last wait cycle, ready shows on the next one
   assign fire = req.valid && !ready_q && (cnt == CNT_W'(MEM_WAIT - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt     <= '0;
         ready_q <= 1'b0;
      end else begin
         ready_q <= fire;
         if (fire) begin
            cnt <= '0;
         end else if (req.valid && !ready_q) begin
            cnt <= cnt + CNT_W'(1);
         end
      end
   end

   // byte lanes
   always_ff @(posedge clk) begin
      if (fire) begin
         rdata_q <= mem[req.addr];
         for (int b = 0; b < STRB_W; b++) begin
            if (req.wstrb[b]) begin
               mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   assign resp = '{rdata: rdata_q, ready: ready_q};

   // masters keep valid up to and including the ready cycle
   a_ready_valid: assert property (@(posedge clk) disable iff (rst)
      resp.ready |-> req.valid);

endmodule

/* source/bus_merge.sv */
`timescale 1ns/1ps

module bus_merge
   import versat_io_pkg::*;
#(
   parameter int N_MASTERS = 3
) (
   input  logic                        clk,
   input  logic                        rst,
   input  bus_req_t  [N_MASTERS-1:0]   m_req,
   input  bus_resp_t                   s_resp,
   output bus_resp_t [N_MASTERS-1:0]   m_resp,
   output bus_req_t                    s_req
);

   localparam int SEL_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

   logic [SEL_W-1:0]     prio;
   logic [SEL_W-1:0]     sel;
   logic [SEL_W-1:0]     sel_reg;
   logic                 locked;
   logic [N_MASTERS-1:0] m_valid;
   logic [N_MASTERS-1:0] m_ready;

   // highest valid index wins
   always_comb begin
      prio = '0;
      for (int k = 0; k < N_MASTERS; k++) begin
         if (m_req[k].valid) begin
            prio = SEL_W'(k);
         end
      end
   end

   assign sel   = locked ? sel_reg : prio;
   assign s_req = m_req[sel];

   // lock from the first valid cycle until the slave answers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         locked  <= 1'b0;
         sel_reg <= '0;
      end else begin
         sel_reg <= sel;
         if (locked) begin
            if (s_resp.ready) begin
               locked <= 1'b0;
            end
         end else if (s_req.valid) begin
            locked <= 1'b1;
         end
      end
   end

   // response goes back to the registered grant
   always_comb begin
      for (int j = 0; j < N_MASTERS; j++) begin
         m_resp[j]  = (SEL_W'(j) == sel_reg) ? s_resp : '0;
         m_valid[j] = m_req[j].valid;
         m_ready[j] = m_resp[j].ready;
      end
   end

   // granted request stays put until the slave answers
   a_sel_locked: assert property (@(posedge clk) disable iff (rst)
      locked && !s_resp.ready |=> s_req.valid && $stable(s_req));

   // ready only reaches a master that still requests
   a_ready_to_req: assert property (@(posedge clk) disable iff (rst)
      (m_ready & ~m_valid) == '0);

endmodule

/* source/io_copy_unit.sv */
`timescale 1ns/1ps

module io_copy_unit
   import versat_io_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  copy_cfg_t cfg,
   input  logic      start,
   input  bus_resp_t bus_resp,
   output logic      busy,
   output bus_req_t  bus_req
);

   copy_state_e state;
   copy_cfg_t   cfg_q;
   len_t        idx;
   len_t        idx_next;
   data_t       data_q;
   logic        accept;

   // zero length or busy starts are dropped
   assign accept   = (state == copy_idle) && start && (cfg.len != '0);
   assign idx_next = idx + len_t'(1);
   assign busy     = (state != copy_idle);

   // one read then one write per word
   always_comb begin
      bus_req = '0;
      case (state)
         copy_read: begin
            bus_req.valid = 1'b1;
            bus_req.addr  = cfg_q.src + idx;
         end
         copy_write: begin
            bus_req.valid = 1'b1;
            bus_req.addr  = cfg_q.dst + idx;
            bus_req.wdata = data_q;
            bus_req.wstrb = '1;
         end
         default: begin
            bus_req = '0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= copy_idle;
         idx   <= '0;
      end else begin
         case (state)
            copy_idle: begin
               if (accept) begin
                  idx   <= '0;
                  state <= copy_read;
               end
            end
            copy_read: begin
               if (bus_resp.ready) begin
                  state <= copy_write;
               end
            end
            copy_write: begin
               if (bus_resp.ready) begin
                  if (idx_next == cfg_q.len) begin
                     state <= copy_idle;
                  end else begin
                     idx   <= idx_next;
                     state <= copy_read;
                  end
               end
            end
            default: begin
               state <= copy_idle;
            end
         endcase
      end
   end

   // config and word in flight
   always_ff @(posedge clk) begin
      if (accept) begin
         cfg_q <= cfg;
      end
      if (state == copy_read && bus_resp.ready) begin
         data_q <= bus_resp.rdata;
      end
   end

   // ready only for the request this unit holds
   a_ready_held: assert property (@(posedge clk) disable iff (rst)
      bus_resp.ready |-> bus_req.valid);

endmodule

/* source/cpu_reg_decode.sv */
`timescale 1ns/1ps

module cpu_reg_decode
   import versat_io_pkg::*;
#(
   parameter int N_UNITS = 2
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      valid,
   input  cpu_addr_t                 addr,
   input  data_t                     wdata,
   input  strb_t                     wstrb,
   input  logic [N_UNITS-1:0]        busy,
   input  bus_resp_t                 mem_resp,
   output data_t                     rdata,
   output logic                      ready,
   output copy_cfg_t [N_UNITS-1:0]   cfg,
   output logic [N_UNITS-1:0]        start,
   output bus_req_t                  mem_req
);

   logic              win;
   logic [UNIT_W-1:0] unit;
   reg_sel_e          rsel;
   logic              reg_acc;
   logic              reg_ready;
   data_t             reg_rdata;
   data_t             rd_val;

   assign win  = addr[WIN_BIT];
   assign unit = addr[UNIT_MSB:UNIT_LSB];
   assign rsel = reg_sel_e'(addr[REG_MSB:0]);

   // first cycle of a register access, the held cycle is masked by ready
   assign reg_acc = valid && !win && !reg_ready;

   // register readback, unused unit index reads zero
   always_comb begin
      rd_val = '0;
      for (int k = 0; k < N_UNITS; k++) begin
         if (unit == UNIT_W'(k)) begin
            case (rsel)
               reg_src:  rd_val = data_t'(cfg[k].src);
               reg_dst:  rd_val = data_t'(cfg[k].dst);
               reg_len:  rd_val = data_t'(cfg[k].len);
               reg_ctrl: rd_val = data_t'(busy[k]);
            endcase
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         reg_ready <= 1'b0;
         start     <= '0;
         cfg       <= '0;
      end else begin
         reg_ready <= reg_acc;
         start     <= '0;
         if (reg_acc && wstrb != '0) begin
            for (int k = 0; k < N_UNITS; k++) begin
               if (unit == UNIT_W'(k)) begin
                  case (rsel)
                     reg_src:  cfg[k].src <= mem_addr_t'(wdata);
                     reg_dst:  cfg[k].dst <= mem_addr_t'(wdata);
                     reg_len:  cfg[k].len <= len_t'(wdata);
                     reg_ctrl: start[k]   <= 1'b1;
                  endcase
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reg_acc) begin
         reg_rdata <= rd_val;
      end
   end

   // memory window goes out as master 0
   assign mem_req = '{
      valid: valid && win,
      addr:  mem_addr_t'(addr),
      wdata: wdata,
      wstrb: wstrb
   };

   // merge zeroes the response unless master 0 was granted
   assign ready = reg_ready || mem_resp.ready;
   assign rdata = reg_ready ? reg_rdata : mem_resp.rdata;

endmodule

/* source/versat_io_pkg.sv */
package versat_io_pkg;

   // widths
   localparam int DATA_W    = 32;
   localparam int STRB_W    = DATA_W / 8;
   localparam int MEM_AW    = 10;
   localparam int MEM_WORDS = 1 << MEM_AW;
   localparam int CPU_AW    = 12;
   localparam int LEN_W     = 10;

   // cpu address map
   localparam int WIN_BIT  = 11;
   localparam int UNIT_MSB = 5;
   localparam int UNIT_LSB = 2;
   localparam int UNIT_W   = UNIT_MSB - UNIT_LSB + 1;
   localparam int REG_MSB  = 1;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [MEM_AW-1:0] mem_addr_t;
   typedef logic [CPU_AW-1:0] cpu_addr_t;
   typedef logic [LEN_W-1:0]  len_t;

   typedef enum logic [REG_MSB:0] {
      reg_src  = 2'd0,
      reg_dst  = 2'd1,
      reg_len  = 2'd2,
      reg_ctrl = 2'd3
   } reg_sel_e;

   // native bus, wstrb of zero is a read
   typedef struct packed {
      logic      valid;
      mem_addr_t addr;
      data_t     wdata;
      strb_t     wstrb;
   } bus_req_t;

   typedef struct packed {
      data_t rdata;
      logic  ready;
   } bus_resp_t;

   typedef struct packed {
      mem_addr_t src;
      mem_addr_t dst;
      len_t      len;
   } copy_cfg_t;

   typedef enum logic [1:0] {
      copy_idle,
      copy_read,
      copy_write
   } copy_state_e;

endpackage
